//--- hw/trig_pkg.sv
`default_nettype none

package trig_pkg;

	// step of the pattern rotation, one step per accepted trigger
	typedef logic [1:0] token_t;

	localparam token_t TOKEN_FIRST  = 2'd0;
	localparam token_t TOKEN_SECOND = 2'd1;
	localparam token_t TOKEN_THIRD  = 2'd2;
	localparam token_t TOKEN_FOURTH = 2'd3;

	// flops on the raw trigger input ahead of edge detection
	localparam int SYNC_STAGES = 2;

	// clocks between self-trigger events
	localparam int SELF_PERIOD = 64;
	localparam int SELF_CNT_WIDTH = $clog2(SELF_PERIOD);

	// pulse-width patterns, msb leaves the line first
	// high time shrinks by one bit per step
	localparam logic [7:0] PATTERN_FIRST  = 8'b1111_0000;
	localparam logic [7:0] PATTERN_SECOND = 8'b1110_0000;
	localparam logic [7:0] PATTERN_THIRD  = 8'b1100_0000;
	localparam logic [7:0] PATTERN_FOURTH = 8'b1000_0000;

endpackage

`default_nettype wire

//--- hw/serdes_pkg.sv
`default_nettype none

package serdes_pkg;

	// bits per serial word
	localparam int WORD_WIDTH = 8;

	// width of the bit counter in the serializer
	localparam int BIT_CNT_WIDTH = $clog2(WORD_WIDTH);

	// one parallel word as handed to the serializer
	typedef logic [WORD_WIDTH-1:0] word_t;

	// line level between words
	localparam logic IDLE_LEVEL = 1'b0;

endpackage

`default_nettype wire

//--- hw/trigger_decode.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_decode (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_input,
	input  logic self_mode,
	output logic trig_event
);
	import trig_pkg::*;

	// synchronizer chain with the raw pin at index 0
	logic [SYNC_STAGES-1:0] sync_q;
	// two earlier synchronized samples with the newest in bit 0
	logic [1:0] hist_q;
	logic trig_level;
	logic edge_seen;

	logic self_mode_q;
	logic self_entry;
	logic [SELF_CNT_WIDTH-1:0] period_cnt;
	logic period_wrap;

	assign trig_level = sync_q[SYNC_STAGES-1];

	// low, low, then high
	assign edge_seen = trig_level && (hist_q == 2'b00);

	assign self_entry = self_mode && !self_mode_q;
	assign period_wrap = (period_cnt == SELF_CNT_WIDTH'(SELF_PERIOD - 1));

	// input synchronizer and history
	always_ff @(posedge clock) begin
		if (reset1) begin
			sync_q <= '0;
			hist_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], trigger_input};
			hist_q <= {hist_q[0], trig_level};
		end
	end

	// self-trigger period counter
	always_ff @(posedge clock) begin
		if (reset1) begin
			self_mode_q <= 1'b0;
			period_cnt <= '0;
		end else begin
			self_mode_q <= self_mode;
			if (!self_mode || self_entry) begin
				// start a fresh period on entry
				period_cnt <= '0;
			end else if (period_wrap) begin
				period_cnt <= '0;
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
		end
	end

	// one clock wide event
	// the external input is ignored while the timer runs
	always_ff @(posedge clock) begin
		if (reset1) begin
			trig_event <= 1'b0;
		end else if (self_mode) begin
			trig_event <= period_wrap;
		end else begin
			trig_event <= edge_seen;
		end
	end

endmodule

`default_nettype wire

//--- hw/pattern_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_sequencer (
	input  logic clock,
	input  logic reset1,
	input  logic trig_event,
	input  logic ack,
	output logic req,
	output serdes_pkg::word_t word,
	output logic sync,
	output logic busy
);
	import trig_pkg::*;
	import serdes_pkg::*;

	token_t token_q;
	logic accept;
	word_t next_word;

	// pattern for the current step
	function automatic word_t select_pattern(input token_t step);
		word_t pattern;
		case (step)
			TOKEN_FIRST:  pattern = word_t'(PATTERN_FIRST);
			TOKEN_SECOND: pattern = word_t'(PATTERN_SECOND);
			TOKEN_THIRD:  pattern = word_t'(PATTERN_THIRD);
			TOKEN_FOURTH: pattern = word_t'(PATTERN_FOURTH);
			default:      pattern = word_t'(PATTERN_FIRST);
		endcase
		return pattern;
	endfunction

	// events during a handshake are dropped and do not move the token
	assign accept = trig_event && !req && !ack;
	assign next_word = select_pattern(token_q);

	assign busy = req | ack;

	// token rotation and request side of the handshake
	always_ff @(posedge clock) begin
		if (reset1) begin
			token_q <= TOKEN_FIRST;
			req <= 1'b0;
		end else if (accept) begin
			token_q <= token_t'(token_q + 1'b1);
			req <= 1'b1;
		end else if (req && ack) begin
			// word taken, release the request
			req <= 1'b0;
		end
	end

	// sync marks the span from the first pattern to the second
	always_ff @(posedge clock) begin
		if (reset1) begin
			sync <= 1'b0;
		end else if (accept) begin
			if (token_q == TOKEN_FIRST) begin
				sync <= 1'b1;
			end else if (token_q == TOKEN_SECOND) begin
				sync <= 1'b0;
			end
		end
	end

	// held stable while req is high
	always_ff @(posedge clock) begin
		if (accept) begin
			word <= next_word;
		end
	end

endmodule

`default_nettype wire

//--- hw/word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_serializer (
	input  logic clock,
	input  logic reset1,
	input  logic req,
	input  serdes_pkg::word_t word,
	output logic ack,
	output logic serial_out
);
	import serdes_pkg::*;

	word_t shift_q;
	logic active;
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;
	logic start;
	logic last_bit;

	// a new request only shows up with ack low and the line idle
	assign start = req && !ack && !active;

	// eighth bit is on the line
	assign last_bit = active && (bit_cnt == BIT_CNT_WIDTH'(WORD_WIDTH - 1));

	// msb of the shift register drives the line while a word is out
	assign serial_out = active ? shift_q[WORD_WIDTH-1] : IDLE_LEVEL;

	// acknowledge side and bit counting
	always_ff @(posedge clock) begin
		if (reset1) begin
			ack <= 1'b0;
			active <= 1'b0;
			bit_cnt <= '0;
		end else if (start) begin
			ack <= 1'b1;
			active <= 1'b1;
			bit_cnt <= '0;
		end else if (active) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (last_bit) begin
				active <= 1'b0;
				// req normally dropped long ago
				if (!req) begin
					ack <= 1'b0;
				end
			end
		end else if (ack && !req) begin
			// late release of req
			ack <= 1'b0;
		end
	end

	// shift register, refilled with the idle level from the bottom
	always_ff @(posedge clock) begin
		if (start) begin
			shift_q <= word;
		end else if (active) begin
			shift_q <= {shift_q[WORD_WIDTH-2:0], IDLE_LEVEL};
		end
	end

endmodule

`default_nettype wire

//--- hw/trigger_serdes_top.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_serdes_top (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_input,
	input  logic self_mode,
	output logic serial_out,
	output logic sync,
	output logic busy
);
	import serdes_pkg::*;

	logic trig_event;
	logic req;
	logic ack;
	word_t word;

	// edge finder and self-trigger timer
	trigger_decode i_trigger_decode (
		.clock         (clock),
		.reset1        (reset1),
		.trigger_input (trigger_input),
		.self_mode     (self_mode),
		.trig_event    (trig_event)
	);

	// token and pattern choice, request side
	pattern_sequencer i_pattern_sequencer (
		.clock      (clock),
		.reset1     (reset1),
		.trig_event (trig_event),
		.ack        (ack),
		.req        (req),
		.word       (word),
		.sync       (sync),
		.busy       (busy)
	);

	// acknowledge side and serial line
	word_serializer i_word_serializer (
		.clock      (clock),
		.reset1     (reset1),
		.req        (req),
		.word       (word),
		.ack        (ack),
		.serial_out (serial_out)
	);

endmodule

`default_nettype wire

//--- test/trigger_serdes_props.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_serdes_props (
	input logic clock,
	input logic reset1,
	input logic req,
	input logic ack,
	input logic serial_out
);
	import serdes_pkg::*;

	int fail_count = 0;

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clock) disable iff (reset1)
		$rose(ack) |-> $past(req))
	else begin
		fail_count++;
		$error("ack rose while req was low");
	end

	// four-phase rule on the request side
	req_waits_for_ack: assert property (@(posedge clock) disable iff (reset1)
		$rose(req) |-> !$past(ack))
	else begin
		fail_count++;
		$error("req rose while ack was still high");
	end

	line_idle_without_ack: assert property (@(posedge clock) disable iff (reset1)
		!ack |-> (serial_out == IDLE_LEVEL))
	else begin
		fail_count++;
		$error("serial_out left the idle level with ack low");
	end

	// a whole word goes out before ack can drop
	ack_covers_word: assert property (@(posedge clock) disable iff (reset1)
		$rose(ack) |-> ack [*WORD_WIDTH])
	else begin
		fail_count++;
		$error("ack fell before the word was shifted out");
	end

endmodule

bind word_serializer trigger_serdes_props i_trigger_serdes_props (
	.clock      (clock),
	.reset1     (reset1),
	.req        (req),
	.ack        (ack),
	.serial_out (serial_out)
);

`default_nettype wire

//--- test/tb_trigger_serdes.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trigger_serdes;
	import trig_pkg::*;
	import serdes_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 20;
	localparam int FIRST_BIT_LIMIT = 12;
	localparam int WORD_LIMIT = FIRST_BIT_LIMIT + WORD_WIDTH + 2;
	localparam int MIN_GAP = 15;
	localparam int HOLD_CYCLES = 40;
	localparam int QUIET_CYCLES = 20;
	localparam int SELF_WORDS = 5;

	// rough length of all tests in clocks
	localparam int RUN_CYCLES = RESET_CYCLES + IDLE_CYCLES
		+ 5 * (2 * MIN_GAP + WORD_LIMIT)
		+ 2 * (2 * MIN_GAP + WORD_LIMIT) + QUIET_CYCLES
		+ 2 * MIN_GAP + HOLD_CYCLES + WORD_LIMIT + QUIET_CYCLES
		+ 2 * MIN_GAP + SELF_WORDS * (SELF_PERIOD + WORD_LIMIT) + QUIET_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

	logic clock;
	logic reset1;
	logic trigger_input;
	logic self_mode;
	logic serial_out;
	logic sync;
	logic busy;

	// words seen on the line and the time of their first bit
	logic [7:0] words_q[$];
	time starts_q[$];

	int error_count;
	integer seed;
	int exp_step;
	logic exp_sync;
	logic toggle_input;

	trigger_serdes_top i_trigger_serdes_top (
		.clock         (clock),
		.reset1        (reset1),
		.trigger_input (trigger_input),
		.self_mode     (self_mode),
		.serial_out    (serial_out),
		.sync          (sync),
		.busy          (busy)
	);

	initial begin
		clock = 1'b0;
	end

	always #(CLK_PERIOD / 2) clock = ~clock;

	// expected rotation with the msb leaving first
	function automatic logic [7:0] expected_pattern(input int step);
		case (step)
			0: return 8'b1111_0000;
			1: return 8'b1110_0000;
			2: return 8'b1100_0000;
			default: return 8'b1000_0000;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic report(input string what);
		$display("error at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// each word opens with a high bit and is sampled mid-bit
	task automatic capture_word(output logic [7:0] bits, output time start);
		do begin
			@(negedge clock);
		end while (serial_out !== 1'b1);
		start = $time;
		bits[7] = 1'b1;
		for (int i = WORD_WIDTH - 2; i >= 0; i--) begin
			@(negedge clock);
			bits[i] = serial_out;
		end
	endtask

	initial begin : serial_monitor
		logic [7:0] bits;
		time start;
		forever begin
			capture_word(bits, start);
			words_q.push_back(bits);
			starts_q.push_back(start);
		end
	end

	task automatic wait_word(input int limit, output logic found);
		int n;
		found = 1'b0;
		for (n = 0; n < limit; n++) begin
			if (words_q.size() > 0) begin
				break;
			end
			// noise on the pin while the timer runs
			if (toggle_input && (n % 3 == 0)) begin
				trigger_input = ~trigger_input;
			end
			next_cycle();
		end
		found = (words_q.size() > 0);
	endtask

	task automatic expect_word(input int limit, output time start);
		logic found;
		logic [7:0] bits;
		start = 0;
		wait_word(limit, found);
		if (!found) begin
			report($sformatf("no word on serial_out within %0d cycles", limit));
		end else begin
			bits = words_q.pop_front();
			start = starts_q.pop_front();
			check("serial_out word", bits, expected_pattern(exp_step));
			// sync set by the first step and cleared by the second
			if (exp_step == 0) begin
				exp_sync = 1'b1;
			end else if (exp_step == 1) begin
				exp_sync = 1'b0;
			end
			check("sync", sync, exp_sync);
			exp_step = (exp_step + 1) % 4;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy !== 1'b0 && n < WORD_LIMIT) begin
			next_cycle();
			n++;
		end
		if (busy !== 1'b0) begin
			report("busy stayed high after the word was sent");
		end
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) next_cycle();
		if (words_q.size() != 0) begin
			report($sformatf("%0d unexpected word(s) on serial_out", words_q.size()));
			words_q.delete();
			starts_q.delete();
		end
	endtask

	task automatic pulse_trigger(input int len);
		trigger_input = 1'b1;
		repeat (len) next_cycle();
		trigger_input = 1'b0;
	endtask

	task automatic idle_gap();
		int gap;
		gap = MIN_GAP + ({$random(seed)} % 16);
		repeat (gap) next_cycle();
	endtask

	task automatic send_trigger();
		time t0;
		time start;
		t0 = $time;
		pulse_trigger(2);
		expect_word(WORD_LIMIT, start);
		if (start != 0 && start - t0 > FIRST_BIT_LIMIT * CLK_PERIOD) begin
			report("first serial bit came too late after the trigger");
		end
		wait_idle();
	endtask

	task automatic test_reset_idle();
		repeat (IDLE_CYCLES) begin
			next_cycle();
			check("serial_out", serial_out, 1'b0);
			check("sync", sync, 1'b0);
			check("busy", busy, 1'b0);
		end
		check("words after reset", words_q.size(), 0);
	endtask

	task automatic test_rotation();
		for (int i = 0; i < 5; i++) begin
			idle_gap();
			send_trigger();
		end
	endtask

	task automatic test_busy_drop();
		time start;
		int n;
		idle_gap();
		pulse_trigger(2);
		n = 0;
		while (busy !== 1'b1 && n < FIRST_BIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (busy !== 1'b1) begin
			report("busy did not rise after a trigger");
		end
		// second edge reaches the sequencer mid-word
		next_cycle();
		pulse_trigger(2);
		expect_word(WORD_LIMIT, start);
		wait_idle();
		check_quiet(QUIET_CYCLES);
		idle_gap();
		send_trigger();
	endtask

	task automatic test_held_trigger();
		time start;
		idle_gap();
		trigger_input = 1'b1;
		expect_word(WORD_LIMIT, start);
		repeat (HOLD_CYCLES) next_cycle();
		trigger_input = 1'b0;
		wait_idle();
		check_quiet(QUIET_CYCLES);
	endtask

	task automatic test_self_mode();
		time start;
		time last_start;
		time spacing;
		last_start = 0;
		idle_gap();
		self_mode = 1'b1;
		toggle_input = 1'b1;
		for (int i = 0; i < SELF_WORDS; i++) begin
			expect_word(SELF_PERIOD + WORD_LIMIT, start);
			if (i > 0 && start != 0 && last_start != 0) begin
				spacing = start - last_start;
				if (spacing < (SELF_PERIOD - 1) * CLK_PERIOD ||
						spacing > (SELF_PERIOD + 1) * CLK_PERIOD) begin
					report($sformatf("self-trigger words %0t apart", spacing));
				end
			end
			last_start = start;
		end
		toggle_input = 1'b0;
		trigger_input = 1'b0;
		repeat (4) next_cycle();
		self_mode = 1'b0;
		check_quiet(QUIET_CYCLES);
	endtask

	task automatic finish_run();
		int props_fails;
		props_fails = i_trigger_serdes_top.i_word_serializer.i_trigger_serdes_props.fail_count;
		$display("errors: %0d checks, %0d assertions", error_count, props_fails);
		if (error_count == 0 && props_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not end within %0d clock cycles, %0d errors so far",
			WATCHDOG_CYCLES, error_count);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		seed = 29084;
		error_count = 0;
		exp_step = 0;
		exp_sync = 1'b0;
		toggle_input = 1'b0;
		reset1 = 1'b1;
		trigger_input = 1'b0;
		self_mode = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset1 = 1'b0;
		test_reset_idle();
		test_rotation();
		test_busy_drop();
		test_held_trigger();
		test_self_mode();
		finish_run();
	end

endmodule

`default_nettype wire

//--- filelist.f
hw/trig_pkg.sv
hw/serdes_pkg.sv
hw/trigger_decode.sv
hw/pattern_sequencer.sv
hw/word_serializer.sv
hw/trigger_serdes_top.sv
test/trigger_serdes_props.sv
test/tb_trigger_serdes.sv

//--- Bender.yml
package:
  name: trigger_serdes

sources:
  # packages first, then blocks, then the top level
  - hw/trig_pkg.sv
  - hw/serdes_pkg.sv
  - hw/trigger_decode.sv
  - hw/pattern_sequencer.sv
  - hw/word_serializer.sv
  - hw/trigger_serdes_top.sv

  - target: test
    files:
      - test/trigger_serdes_props.sv
      - test/tb_trigger_serdes.sv
